// ==== vlog.f ====
hdl/axi_master_pkg.sv
hdl/read_port.sv
hdl/r_router.sv
hdl/ar_arbiter.sv
hdl/write_engine.sv
hdl/axi_master_top.sv
bench/axi_master_props.sv
bench/tb_axi_master.sv

// ==== bench/tb_axi_master.sv ====
`timescale 1ns/100ps

module tb_axi_master
    import axi_master_pkg::*;
();

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int LINE_W  = DATA_W * BURST_BEATS;
    localparam int TIMEOUT = 200;

    int     assert_errs = 0; // raised by the bound assertions
    int     timeout_errs = 0;
    integer seed = 32'h409a5dbc;

    logic                aclk = 1'b0;
    logic                aresetn = 1'b0;
    logic                i_req_i = 1'b0;
    logic [ADDR_W-1:0]   i_addr_i = '0;
    logic                i_burst_i = 1'b0;
    logic                d_req_i = 1'b0;
    logic [ADDR_W-1:0]   d_addr_i = '0;
    logic                d_burst_i = 1'b0;
    logic                wr_req_i = 1'b0;
    logic [ADDR_W-1:0]   wr_addr_i = '0;
    logic                wr_burst_i = 1'b0;
    logic [DATA_W/8-1:0] wr_strb_i = '0;
    logic [LINE_W-1:0]   wr_line_i = '0;
    logic                m_arready_i = 1'b0;
    logic [ID_W-1:0]     m_rid_i = '0;
    logic [DATA_W-1:0]   m_rdata_i = '0;
    logic                m_rlast_i = 1'b0;
    logic                m_rvalid_i = 1'b0;
    logic                m_awready_i = 1'b0;
    logic                m_wready_i = 1'b0;
    logic                m_bvalid_i = 1'b0;

    logic i_rdy_o, i_ret_valid_o, i_ret_last_o, d_rdy_o, d_ret_valid_o, d_ret_last_o;
    logic wr_rdy_o, wr_busy_o, m_arvalid_o, m_rready_o, m_awvalid_o;
    logic m_wlast_o, m_wvalid_o, m_bready_o;
    logic [DATA_W-1:0]   i_data_o, d_data_o, m_wdata_o;
    logic [ID_W-1:0]     m_arid_o, m_awid_o;
    logic [ADDR_W-1:0]   m_araddr_o, m_awaddr_o;
    logic [LEN_W-1:0]    m_arlen_o, m_awlen_o;
    logic [SIZE_W-1:0]   m_arsize_o, m_awsize_o;
    logic [1:0]          m_arburst_o, m_awburst_o;
    logic [DATA_W/8-1:0] m_wstrb_o;

    // slave side read bookkeeping, one read per ID
    logic [ADDR_W-1:0] rd_addr [N_RD_PORTS];
    logic [LEN_W-1:0]  rd_len [N_RD_PORTS];
    logic [LEN_W-1:0]  rd_cnt [N_RD_PORTS];
    logic [1:0]        rd_pend = '0;
    logic              b_pend = 1'b0;

    axi_master_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut0 (.*);

    bind axi_master_top axi_master_props #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_props (.*);

    initial begin
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) begin : slave_model
        int id;
        if (!aresetn) begin
            rd_pend = '0;
            b_pend  = 1'b0;
            m_arready_i <= 1'b0;
            m_rvalid_i  <= 1'b0;
            m_awready_i <= 1'b0;
            m_wready_i  <= 1'b0;
            m_bvalid_i  <= 1'b0;
        end else begin
            if (m_arvalid_o && m_arready_i) begin
                id = m_arid_o[0];
                rd_addr[id] = m_araddr_o;
                rd_len[id]  = m_arlen_o;
                rd_cnt[id]  = '0;
                rd_pend[id] = 1'b1;
            end
            if (m_rvalid_i && m_rready_o) begin
                id = m_rid_i[0];
                if (m_rlast_i) rd_pend[id] = 1'b0;
                rd_cnt[id] = rd_cnt[id] + 1'b1;
            end
            if (!m_rvalid_i || m_rready_o) begin // beat slot is free
                id = $random(seed) & 1;
                if (!rd_pend[id]) id = 1 - id;
                if (rd_pend[id] && ($random(seed) & 3) != 0) begin
                    m_rvalid_i <= 1'b1;
                    m_rid_i    <= ID_W'(id);
                    m_rdata_i  <= DATA_W'(rd_addr[id] ^ ADDR_W'(rd_cnt[id]));
                    m_rlast_i  <= (rd_cnt[id] == rd_len[id]);
                end else begin
                    m_rvalid_i <= 1'b0;
                end
            end
            if (m_wvalid_o && m_wready_i && m_wlast_o) b_pend = 1'b1;
            if (m_bvalid_i && m_bready_o) begin
                b_pend = 1'b0;
                m_bvalid_i <= 1'b0;
            end else if (!m_bvalid_i && b_pend) begin
                m_bvalid_i <= ($random(seed) & 1) != 0;
            end
            m_arready_i <= ($random(seed) & 1) != 0;
            m_awready_i <= ($random(seed) & 1) != 0;
            m_wready_i  <= ($random(seed) & 1) != 0;
        end
    end

    task automatic report_timeout(input string what);
        timeout_errs++;
        $display("timeout at %0t: %s never happened", $time, what);
    endtask

    function automatic logic [ADDR_W-1:0] random_addr(input int p);
        return {4'(p + 1), 28'($random(seed))}; // top nibble keeps ports apart
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] l;
        for (int k = 0; k < BURST_BEATS; k++) begin
            l[k*DATA_W +: DATA_W] = $random(seed);
        end
        return l;
    endfunction

    task automatic read_line(input int p, input logic [ADDR_W-1:0] a, input logic b);
        int t;
        @(posedge aclk);
        if (p == 0) begin
            i_req_i   <= 1'b1;
            i_addr_i  <= a;
            i_burst_i <= b;
        end else begin
            d_req_i   <= 1'b1;
            d_addr_i  <= a;
            d_burst_i <= b;
        end
        t = 0;
        do begin
            @(posedge aclk);
            t++;
        end while (!(((p == 0) ? i_rdy_o : d_rdy_o) && !wr_busy_o) && t < TIMEOUT);
        if (t >= TIMEOUT) report_timeout("read request acceptance");
        if (p == 0) i_req_i <= 1'b0;
        else d_req_i <= 1'b0;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
        end while (!((p == 0) ? i_ret_last_o : d_ret_last_o) && t < TIMEOUT);
        if (t >= TIMEOUT) report_timeout("last read beat");
    endtask

    task automatic write_line(input logic [ADDR_W-1:0] a, input logic b,
                              input logic [DATA_W/8-1:0] s, input logic [LINE_W-1:0] l);
        int t;
        @(posedge aclk);
        wr_req_i   <= 1'b1;
        wr_addr_i  <= a;
        wr_burst_i <= b;
        wr_strb_i  <= s;
        wr_line_i  <= l;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
        end while (!wr_rdy_o && t < TIMEOUT);
        if (t >= TIMEOUT) report_timeout("write request acceptance");
        wr_req_i <= 1'b0;
        t = 0;
        do begin
            @(posedge aclk);
            t++;
        end while (!(m_bvalid_i && m_bready_o) && t < TIMEOUT);
        if (t >= TIMEOUT) report_timeout("write response");
    endtask

    initial begin : stimulus
        int lag;
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;
        read_line(0, 32'h1000_1000, 1'b0);
        read_line(1, 32'h2000_2040, 1'b0);
        read_line(0, 32'h1000_1100, 1'b1);
        read_line(1, 32'h2000_2200, 1'b1);
        repeat (8) begin
            lag = $random(seed) & 3;
            fork
                read_line(0, random_addr(0), ($random(seed) & 1) != 0);
                begin
                    repeat (lag) @(posedge aclk); // dcache may arrive during a stalled icache AR
                    read_line(1, random_addr(1), ($random(seed) & 1) != 0);
                end
            join
        end
        write_line(32'h3000_0000, 1'b0, 4'hf, random_line());
        write_line(32'h3000_0010, 1'b1, 4'h5, random_line());
        // write and read requested in the same cycle
        repeat (4) begin
            fork
                write_line(random_addr(2), 1'b1, 4'($random(seed)), random_line());
                read_line(0, random_addr(0), 1'b1);
                read_line(1, random_addr(1), 1'b0);
            join
        end
        repeat (10) @(posedge aclk);
        $display("errors: %0d assertion, %0d timeout", assert_errs, timeout_errs);
        if (assert_errs == 0 && timeout_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/axi_master_props.sv ====
`timescale 1ns/100ps

module axi_master_props
    import axi_master_pkg::*;
#(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input logic aclk, aresetn,
    input logic i_req_i, i_burst_i, i_rdy_o, i_ret_valid_o, i_ret_last_o,
    input logic d_req_i, d_burst_i, d_rdy_o, d_ret_valid_o, d_ret_last_o,
    input logic [ADDR_W-1:0] i_addr_i, d_addr_i, m_araddr_o, wr_addr_i, m_awaddr_o,
    input logic [DATA_W-1:0] i_data_o, d_data_o, m_wdata_o,
    input logic wr_req_i, wr_burst_i, wr_rdy_o, wr_busy_o,
    input logic [DATA_W/8-1:0] wr_strb_i, m_wstrb_o,
    input logic [DATA_W*BURST_BEATS-1:0] wr_line_i,
    input logic [ID_W-1:0] m_arid_o, m_awid_o,
    input logic [LEN_W-1:0] m_arlen_o, m_awlen_o,
    input logic [SIZE_W-1:0] m_arsize_o, m_awsize_o,
    input logic [1:0] m_arburst_o, m_awburst_o,
    input logic m_arvalid_o, m_arready_i, m_awvalid_o, m_awready_i,
    input logic m_wlast_o, m_wvalid_o, m_wready_i, m_bvalid_i, m_bready_o
);

    localparam int LINE_W = DATA_W * BURST_BEATS;
    localparam logic [SIZE_W-1:0] WORD_SIZE = SIZE_W'($clog2(DATA_W / 8));
    localparam logic [1:0]        INCR      = 2'b01; // AXI incrementing burst

    logic [N_RD_PORTS-1:0] rd_acc, burst, ret_valid, ret_last;
    logic [ADDR_W-1:0]     req_addr [N_RD_PORTS];
    logic [ADDR_W-1:0]     exp_addr [N_RD_PORTS];
    logic [LEN_W-1:0]      exp_len [N_RD_PORTS];
    logic [LEN_W-1:0]      beat_n [N_RD_PORTS];
    logic [DATA_W-1:0]     ret_data [N_RD_PORTS];
    logic                  wr_act, w_done, aw_done;
    logic [ADDR_W-1:0]     w_addr;
    logic [LEN_W-1:0]      w_n, w_len;
    logic [DATA_W/8-1:0]   w_strb;
    logic [LINE_W-1:0]     w_line;

    assign rd_acc      = {d_req_i & d_rdy_o, i_req_i & i_rdy_o} & ~{N_RD_PORTS{wr_act | wr_req_i}};
    assign burst       = {d_burst_i, i_burst_i};
    assign ret_valid   = {d_ret_valid_o, i_ret_valid_o};
    assign ret_last    = {d_ret_last_o, i_ret_last_o};
    assign req_addr[0] = i_addr_i;
    assign req_addr[1] = d_addr_i;
    assign ret_data[0] = i_data_o;
    assign ret_data[1] = d_data_o;

    always_ff @(posedge aclk) begin
        for (int p = 0; p < N_RD_PORTS; p++) begin
            if (rd_acc[p]) begin
                exp_addr[p] <= req_addr[p];
                exp_len[p]  <= burst[p] ? LEN_W'(BURST_BEATS - 1) : '0;
                beat_n[p]   <= '0;
            end else if (ret_valid[p]) begin
                beat_n[p] <= beat_n[p] + 1'b1;
            end
        end
    end

    // write from acceptance to B handshake
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_act  <= 1'b0;
            w_done  <= 1'b0;
            aw_done <= 1'b0;
        end else begin
            if (wr_req_i && wr_rdy_o) begin
                wr_act  <= 1'b1;
                w_done  <= 1'b0;
                aw_done <= 1'b0;
                w_addr  <= wr_addr_i;
                w_n     <= '0;
                w_len   <= wr_burst_i ? LEN_W'(BURST_BEATS - 1) : '0;
                w_strb  <= wr_strb_i;
                w_line  <= wr_line_i;
            end
            if (m_awvalid_o && m_awready_i) aw_done <= 1'b1;
            if (m_wvalid_o && m_wready_i) begin
                w_n <= w_n + 1'b1;
                if (m_wlast_o) w_done <= 1'b1;
            end
            if (m_bvalid_i && m_bready_o) wr_act <= 1'b0;
        end
    end

    for (genvar p = 0; p < N_RD_PORTS; p++) begin : g_port
        a_read_beat: assert property (@(posedge aclk) disable iff (!aresetn)
            ret_valid[p] |-> beat_n[p] <= exp_len[p]
                && ret_data[p] == DATA_W'(exp_addr[p] ^ ADDR_W'(beat_n[p]))
                && ret_last[p] == (beat_n[p] == exp_len[p]))
        else begin
            $error("mismatch at %0t: read beat %0d on port %0d", $time, beat_n[p], p);
            tb_axi_master.assert_errs++;
        end
    end

    a_ar_fields: assert property (@(posedge aclk) disable iff (!aresetn)
        m_arvalid_o && m_arready_i |-> m_arid_o < N_RD_PORTS
            && m_araddr_o == exp_addr[m_arid_o[0]] && m_arlen_o == exp_len[m_arid_o[0]]
            && m_arsize_o == WORD_SIZE && m_arburst_o == INCR)
    else begin
        $error("mismatch at %0t: AR id %0d addr, len, size or burst", $time, m_arid_o);
        tb_axi_master.assert_errs++;
    end

    a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o) && $stable(m_arid_o))
    else begin
        $error("AR request changed or dropped at %0t while stalled", $time);
        tb_axi_master.assert_errs++;
    end

    a_aw_fields: assert property (@(posedge aclk) disable iff (!aresetn)
        m_awvalid_o && m_awready_i |-> wr_act && !aw_done && m_awaddr_o == w_addr
            && m_awlen_o == w_len && m_awid_o == ID_W'(1)
            && m_awsize_o == WORD_SIZE && m_awburst_o == INCR)
    else begin
        $error("mismatch at %0t: AW addr %0h len %0d", $time, m_awaddr_o, m_awlen_o);
        tb_axi_master.assert_errs++;
    end

    a_w_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        m_wvalid_o && m_wready_i |-> aw_done && w_n <= w_len && m_wstrb_o == w_strb
            && m_wdata_o == w_line[w_n*DATA_W +: DATA_W] && m_wlast_o == (w_n == w_len))
    else begin
        $error("mismatch at %0t: W beat %0d data, strobe or last", $time, w_n);
        tb_axi_master.assert_errs++;
    end

    a_w_count: assert property (@(posedge aclk) disable iff (!aresetn)
        m_bvalid_i && m_bready_o |-> w_n == w_len + 1'b1)
    else begin
        $error("mismatch at %0t: %0d W beats for len %0d", $time, w_n, w_len);
        tb_axi_master.assert_errs++;
    end

    a_bready: assert property (@(posedge aclk) disable iff (!aresetn)
        m_bready_o |-> w_done)
    else begin
        $error("bready raised at %0t before the last W beat", $time);
        tb_axi_master.assert_errs++;
    end

    a_wr_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        wr_busy_o == (wr_act || wr_req_i))
    else begin
        $error("mismatch at %0t: wr_busy %0b with write active %0b", $time, wr_busy_o, wr_act);
        tb_axi_master.assert_errs++;
    end

    a_rd_block: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(m_arvalid_o) |-> !wr_act)
    else begin
        $error("new read issued at %0t while a write was in progress", $time);
        tb_axi_master.assert_errs++;
    end

endmodule

// ==== hdl/axi_master_top.sv ====
`timescale 1ns/100ps

module axi_master_top
    import axi_master_pkg::*;
#(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    // icache read port
    input  logic                          i_req_i,
    input  logic [ADDR_W-1:0]             i_addr_i,
    input  logic                          i_burst_i,
    output logic                          i_rdy_o,
    output logic                          i_ret_valid_o,
    output logic                          i_ret_last_o,
    output logic [DATA_W-1:0]             i_data_o,
    // dcache read port
    input  logic                          d_req_i,
    input  logic [ADDR_W-1:0]             d_addr_i,
    input  logic                          d_burst_i,
    output logic                          d_rdy_o,
    output logic                          d_ret_valid_o,
    output logic                          d_ret_last_o,
    output logic [DATA_W-1:0]             d_data_o,
    // dcache write port
    input  logic                          wr_req_i,
    input  logic [ADDR_W-1:0]             wr_addr_i,
    input  logic                          wr_burst_i,
    input  logic [DATA_W/8-1:0]           wr_strb_i,
    input  logic [DATA_W*BURST_BEATS-1:0] wr_line_i,
    output logic                          wr_rdy_o,
    output logic                          wr_busy_o,
    // AR
    output logic [ID_W-1:0]               m_arid_o,
    output logic [ADDR_W-1:0]             m_araddr_o,
    output logic [LEN_W-1:0]              m_arlen_o,
    output logic [SIZE_W-1:0]             m_arsize_o,
    output logic [1:0]                    m_arburst_o,
    output logic                          m_arvalid_o,
    input  logic                          m_arready_i,
    // R
    input  logic [ID_W-1:0]               m_rid_i,
    input  logic [DATA_W-1:0]             m_rdata_i,
    input  logic                          m_rlast_i,
    input  logic                          m_rvalid_i,
    output logic                          m_rready_o,
    // AW
    output logic [ID_W-1:0]               m_awid_o,
    output logic [ADDR_W-1:0]             m_awaddr_o,
    output logic [LEN_W-1:0]              m_awlen_o,
    output logic [SIZE_W-1:0]             m_awsize_o,
    output logic [1:0]                    m_awburst_o,
    output logic                          m_awvalid_o,
    input  logic                          m_awready_i,
    // W
    output logic [DATA_W-1:0]             m_wdata_o,
    output logic [DATA_W/8-1:0]           m_wstrb_o,
    output logic                          m_wlast_o,
    output logic                          m_wvalid_o,
    input  logic                          m_wready_i,
    // B
    input  logic                          m_bvalid_i,
    output logic                          m_bready_o
);

    // per-port arrays, index 0 icache, 1 dcache
    logic [N_RD_PORTS-1:0] req, burst, rdy, ret_valid, ret_last;
    logic [ADDR_W-1:0]     addr [N_RD_PORTS];
    logic [DATA_W-1:0]     ret_data [N_RD_PORTS];
    logic [N_RD_PORTS-1:0] ar_req, ar_grant, r_wait, beat_valid;
    logic [ADDR_W-1:0]     ar_addr [N_RD_PORTS];
    logic [LEN_W-1:0]      ar_len [N_RD_PORTS];
    logic                  beat_last;
    logic [DATA_W-1:0]     beat_data;

    assign req     = {d_req_i, i_req_i};
    assign burst   = {d_burst_i, i_burst_i};
    assign addr[0] = i_addr_i;
    assign addr[1] = d_addr_i;

    assign i_rdy_o       = rdy[0];
    assign i_ret_valid_o = ret_valid[0];
    assign i_ret_last_o  = ret_last[0];
    assign i_data_o      = ret_data[0];
    assign d_rdy_o       = rdy[1];
    assign d_ret_valid_o = ret_valid[1];
    assign d_ret_last_o  = ret_last[1];
    assign d_data_o      = ret_data[1];

    for (genvar p = 0; p < N_RD_PORTS; p++) begin : g_rd
        read_port #(
            .ADDR_W  (ADDR_W),
            .DATA_W  (DATA_W),
            .PORT_ID (p)
        ) u_read_port (
            .aclk         (aclk),
            .aresetn      (aresetn),
            .req_i        (req[p]),
            .addr_i       (addr[p]),
            .burst_i      (burst[p]),
            .rdy_o        (rdy[p]),
            .ret_valid_o  (ret_valid[p]),
            .ret_last_o   (ret_last[p]),
            .ret_data_o   (ret_data[p]),
            .wr_busy_i    (wr_busy_o),
            .ar_req_o     (ar_req[p]),
            .ar_addr_o    (ar_addr[p]),
            .ar_len_o     (ar_len[p]),
            .ar_grant_i   (ar_grant[p]),
            .beat_valid_i (beat_valid[p]),
            .beat_last_i  (beat_last),
            .beat_data_i  (beat_data),
            .r_wait_o     (r_wait[p])
        );
    end

    ar_arbiter #(.ADDR_W(ADDR_W)) u_ar_arbiter (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .ar_req_i   (ar_req),
        .ar_addr_i  (ar_addr),
        .ar_len_i   (ar_len),
        .ar_grant_o (ar_grant),
        .arready_i  (m_arready_i),
        .arvalid_o  (m_arvalid_o),
        .arid_o     (m_arid_o),
        .araddr_o   (m_araddr_o),
        .arlen_o    (m_arlen_o)
    );

    r_router #(.DATA_W(DATA_W)) u_r_router (
        .rid_i        (m_rid_i),
        .rdata_i      (m_rdata_i),
        .rlast_i      (m_rlast_i),
        .rvalid_i     (m_rvalid_i),
        .rready_o     (m_rready_o),
        .r_wait_i     (r_wait),
        .beat_valid_o (beat_valid),
        .beat_last_o  (beat_last),
        .beat_data_o  (beat_data)
    );

    write_engine #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_write_engine (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .wr_req_i   (wr_req_i),
        .wr_addr_i  (wr_addr_i),
        .wr_burst_i (wr_burst_i),
        .wr_strb_i  (wr_strb_i),
        .wr_line_i  (wr_line_i),
        .wr_rdy_o   (wr_rdy_o),
        .wr_busy_o  (wr_busy_o),
        .awaddr_o   (m_awaddr_o),
        .awlen_o    (m_awlen_o),
        .awvalid_o  (m_awvalid_o),
        .awready_i  (m_awready_i),
        .wdata_o    (m_wdata_o),
        .wstrb_o    (m_wstrb_o),
        .wlast_o    (m_wlast_o),
        .wvalid_o   (m_wvalid_o),
        .wready_i   (m_wready_i),
        .bvalid_i   (m_bvalid_i),
        .bready_o   (m_bready_o)
    );

    // fixed AXI fields
    assign m_arsize_o  = beat_size;
    assign m_arburst_o = BURST_INCR;
    assign m_awid_o    = WRITE_ID;
    assign m_awsize_o  = beat_size;
    assign m_awburst_o = BURST_INCR;

endmodule

// ==== hdl/write_engine.sv ====
`timescale 1ns/100ps

module write_engine
    import axi_master_pkg::*;
#(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    // dcache write port
    input  logic                          wr_req_i,
    input  logic [ADDR_W-1:0]             wr_addr_i,
    input  logic                          wr_burst_i,
    input  logic [DATA_W/8-1:0]           wr_strb_i,
    input  logic [DATA_W*BURST_BEATS-1:0] wr_line_i,
    output logic                          wr_rdy_o,
    output logic                          wr_busy_o,
    // AW
    output logic [ADDR_W-1:0]             awaddr_o,
    output logic [LEN_W-1:0]              awlen_o,
    output logic                          awvalid_o,
    input  logic                          awready_i,
    // W
    output logic [DATA_W-1:0]             wdata_o,
    output logic [DATA_W/8-1:0]           wstrb_o,
    output logic                          wlast_o,
    output logic                          wvalid_o,
    input  logic                          wready_i,
    // B
    input  logic                          bvalid_i,
    output logic                          bready_o
);

    localparam int STRB_W = DATA_W / 8;
    localparam int LINE_W = DATA_W * BURST_BEATS;

    typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_t;

    state_t             state_q;
    logic               accept;
    logic [LEN_W-1:0]   cnt_q;    // W beats already sent
    logic [ADDR_W-1:0]  addr_q;
    logic               burst_q;
    logic [STRB_W-1:0]  strb_q;
    logic [LINE_W-1:0]  line_q;

    assign accept = wr_req_i & wr_rdy_o;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: if (accept) state_q <= st_addr;
                st_addr: begin
                    if (awready_i) begin
                        state_q <= st_data;
                        cnt_q   <= '0;
                    end
                end
                st_data: begin
                    if (wready_i) begin
                        if (wlast_o) state_q <= st_resp;
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                st_resp: if (bvalid_i) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q  <= wr_addr_i;
            burst_q <= wr_burst_i;
            strb_q  <= wr_strb_i;
            line_q  <= wr_line_i;
        end else if (wvalid_o && wready_i) begin
            line_q <= line_q >> DATA_W; // next slice into the low word
        end
    end

    // a write request on an idle port already blocks reads
    assign wr_busy_o = (state_q != st_idle) | wr_req_i;
    assign wr_rdy_o  = (state_q == st_idle);

    assign awvalid_o = (state_q == st_addr);
    assign awaddr_o  = addr_q;
    assign awlen_o   = burst_q ? LEN_W'(BURST_BEATS - 1) : '0;

    assign wvalid_o = (state_q == st_data);
    assign wdata_o  = line_q[DATA_W-1:0];
    assign wstrb_o  = strb_q;
    assign wlast_o  = wvalid_o & (cnt_q == awlen_o);

    assign bready_o = (state_q == st_resp);

endmodule

// ==== hdl/ar_arbiter.sv ====
`timescale 1ns/100ps

module ar_arbiter
    import axi_master_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic [N_RD_PORTS-1:0] ar_req_i,
    input  logic [ADDR_W-1:0]     ar_addr_i [N_RD_PORTS],
    input  logic [LEN_W-1:0]      ar_len_i [N_RD_PORTS],
    output logic [N_RD_PORTS-1:0] ar_grant_o,
    input  logic                  arready_i,
    output logic                  arvalid_o,
    output logic [ID_W-1:0]       arid_o,
    output logic [ADDR_W-1:0]     araddr_o,
    output logic [LEN_W-1:0]      arlen_o
);

    logic [PORT_SEL_W-1:0] prio_sel;
    logic [PORT_SEL_W-1:0] sel;
    logic [PORT_SEL_W-1:0] held_q;
    logic                  held_valid_q;

    // highest requesting index wins, so dcache beats icache
    always_comb begin
        prio_sel = '0;
        for (int p = 0; p < N_RD_PORTS; p++) begin
            if (ar_req_i[p]) prio_sel = PORT_SEL_W'(p);
        end
    end

    // a stalled AR keeps its winner until accepted
    assign sel = held_valid_q ? held_q : prio_sel;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            held_valid_q <= 1'b0;
        end else begin
            held_valid_q <= arvalid_o & ~arready_i;
        end
    end

    always_ff @(posedge aclk) begin
        held_q <= sel;
    end

    assign arvalid_o = |ar_req_i;
    assign arid_o    = ID_W'(sel);
    assign araddr_o  = ar_addr_i[sel];
    assign arlen_o   = ar_len_i[sel];

    always_comb begin
        for (int p = 0; p < N_RD_PORTS; p++) begin
            ar_grant_o[p] = arvalid_o & arready_i & (sel == PORT_SEL_W'(p));
        end
    end

endmodule

// ==== hdl/r_router.sv ====
`timescale 1ns/100ps

module r_router
    import axi_master_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic [ID_W-1:0]       rid_i,
    input  logic [DATA_W-1:0]     rdata_i,
    input  logic                  rlast_i,
    input  logic                  rvalid_i,
    output logic                  rready_o,
    input  logic [N_RD_PORTS-1:0] r_wait_i,
    output logic [N_RD_PORTS-1:0] beat_valid_o,
    output logic                  beat_last_o,
    output logic [DATA_W-1:0]     beat_data_o
);

    logic [PORT_SEL_W-1:0] sel;

    assign sel = rid_i[PORT_SEL_W-1:0]; // low ID bit names the port

    // only the addressed port decides whether the beat is taken
    assign rready_o = r_wait_i[sel];

    always_comb begin
        for (int p = 0; p < N_RD_PORTS; p++) begin
            beat_valid_o[p] = rvalid_i & rready_o & (sel == PORT_SEL_W'(p));
        end
    end

    assign beat_last_o = rlast_i;
    assign beat_data_o = rdata_i;

endmodule

// ==== hdl/read_port.sv ====
`timescale 1ns/100ps

module read_port
    import axi_master_pkg::*;
#(
    parameter int ADDR_W  = 32,
    parameter int DATA_W  = 32,
    parameter int PORT_ID = 0
) (
    input  logic              aclk,
    input  logic              aresetn,
    // cache side
    input  logic              req_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              burst_i,
    output logic              rdy_o,
    output logic              ret_valid_o,
    output logic              ret_last_o,
    output logic [DATA_W-1:0] ret_data_o,
    input  logic              wr_busy_i,
    // towards the AR arbiter
    output logic              ar_req_o,
    output logic [ADDR_W-1:0] ar_addr_o,
    output logic [LEN_W-1:0]  ar_len_o,
    input  logic              ar_grant_i,
    // from the R router
    input  logic              beat_valid_i,
    input  logic              beat_last_i,
    input  logic [DATA_W-1:0] beat_data_i,
    output logic              r_wait_o
);

    typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

    state_t            state_q;
    logic              accept;
    logic [ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]  len_q;

    if (PORT_ID >= N_RD_PORTS) begin : g_id_check
        $error("read_port PORT_ID %0d outside the port range", PORT_ID);
    end

    // no new read while the write side is busy
    assign accept = req_i & rdy_o & ~wr_busy_i;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: if (accept) state_q <= st_addr;
                st_addr: if (ar_grant_i) state_q <= st_data;
                st_data: if (beat_valid_i && beat_last_i) state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= addr_i;
            len_q  <= burst_i ? LEN_W'(BURST_BEATS - 1) : '0;
        end
    end

    assign rdy_o     = (state_q == st_idle);
    assign ar_req_o  = (state_q == st_addr);
    assign ar_addr_o = addr_q;
    assign ar_len_o  = len_q;
    assign r_wait_o  = (state_q == st_data);

    // beats pass straight through to the cache
    assign ret_valid_o = beat_valid_i & r_wait_o;
    assign ret_last_o  = ret_valid_o & beat_last_i;
    assign ret_data_o  = beat_data_i;

endmodule

// ==== hdl/axi_master_pkg.sv ====
package axi_master_pkg;

    // read ports, index doubles as the AR ID
    localparam int N_RD_PORTS = 2; // 0 = icache, 1 = dcache
    localparam int PORT_SEL_W = $clog2(N_RD_PORTS);

    // AXI field widths
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int SIZE_W = 3;

    // cache line transfer
    localparam int BURST_BEATS = 4;

    localparam logic [1:0]        BURST_INCR = 2'b01;
    localparam logic [ID_W-1:0]   WRITE_ID   = 4'd1;
    localparam logic [SIZE_W-1:0] beat_size  = 3'd2; // 4 bytes per beat

endpackage
